//--- hw/tart_pkg.sv
`default_nettype none

package tart_pkg;

   // --------------------------------------------------
   // Widths
   // --------------------------------------------------
   localparam int NUM_ANTENNA = 8;        // One bit per antenna
   localparam int DELAY_W     = 3;        // Sample delay 0..7
   localparam int DELAY_TAPS  = 1 << DELAY_W;

   typedef logic [7:0]             bus_data_t;  // Bus data, register contents
   typedef logic [6:0]             bus_adr_t;   // Low 7 bits of SPI command
   typedef logic [NUM_ANTENNA-1:0] ax_data_t;   // Raw antenna sample word
   typedef logic [DELAY_W-1:0]     ax_delay_t;

   // Software reset stretch, in b_clk cycles
   localparam int RESET_CYCLES = 4;
   localparam int RST_CNT_W    = $clog2(RESET_CYCLES + 1);

   // --------------------------------------------------
   // Address map
   // --------------------------------------------------
   localparam bus_adr_t ADR_ACQ_CTRL    = 7'h00; // Enable, delay
   localparam bus_adr_t ADR_ACQ_CSUM    = 7'h01; // Read only
   localparam bus_adr_t ADR_ACQ_SAMPLE  = 7'h02; // Read only
   localparam bus_adr_t ADR_CTL_RESET   = 7'h78;
   localparam bus_adr_t ADR_CTL_SCRATCH = 7'h79;

   localparam logic [2:0] ACQ_REGION = 3'b000;  // adr[6:4]
   localparam logic [3:0] CTL_REGION = 4'b1111; // adr[6:3]

   // Bridge FSM
   typedef enum logic [2:0] {IDLE, CMD, BUS_READ, DATA, BUS_WRITE} spi_state_t;

endpackage

`default_nettype wire

//--- hw/spi_bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bus_bridge (
   input  wire                 b_clk,
   input  wire                 arst_n_i,
   input  wire                 spi_sck_i,
   input  wire                 spi_ssel_i,   // Active low
   input  wire                 spi_mosi_i,
   output logic                spi_miso_o,
   output logic                bus_cyc_o,
   output logic                bus_stb_o,
   output logic                bus_we_o,
   output tart_pkg::bus_adr_t  bus_adr_o,
   output tart_pkg::bus_data_t bus_dat_o,
   input  wire                 bus_ack_i,
   input  wire tart_pkg::bus_data_t bus_dat_i
);
   import tart_pkg::*;

   logic [2:0] sck_q;        // Two sync stages plus history
   logic [2:0] ssel_q;
   logic [1:0] mosi_q;       // Kept in step with sck_q[1]
   logic       sck_rise;
   logic       sck_fall;
   logic       ssel_fall;
   logic       ssel_rise;

   spi_state_t state_q;
   logic [2:0] bit_cnt_q;    // Bit position within byte
   bus_data_t  shift_q;      // MOSI shifter
   bus_data_t  cmd_q;        // {we, adr}
   bus_data_t  miso_sr_q;    // Read byte on its way out
   logic       stb_q;

   // --------------------------------------------------
   // Pin synchronisers and edge pulses
   // --------------------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sck_q  <= 3'b000;
         ssel_q <= 3'b111;   // Deselected
         mosi_q <= 2'b00;
      end else begin
         sck_q  <= {sck_q[1:0], spi_sck_i};
         ssel_q <= {ssel_q[1:0], spi_ssel_i};
         mosi_q <= {mosi_q[0], spi_mosi_i};
      end
   end

   assign sck_rise  =  sck_q[1] & ~sck_q[2];
   assign sck_fall  = ~sck_q[1] &  sck_q[2];
   assign ssel_fall = ~ssel_q[1] &  ssel_q[2];  // Frame start
   assign ssel_rise =  ssel_q[1] & ~ssel_q[2];  // Frame end or abort

   // MOSI sampled on rising SCK
   always_ff @(posedge b_clk) begin
      if (sck_rise)
         shift_q <= {shift_q[6:0], mosi_q[1]};
   end

   // --------------------------------------------------
   // Frame FSM
   // --------------------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= IDLE;
         bit_cnt_q  <= 3'd0;
         cmd_q      <= '0;
         miso_sr_q  <= '0;
         stb_q      <= 1'b0;
         spi_miso_o <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               spi_miso_o <= 1'b0;
               if (ssel_fall) begin
                  bit_cnt_q <= 3'd0;
                  state_q   <= CMD;
               end
            end
            CMD: begin
               spi_miso_o <= 1'b0;             // Zero during command byte
               if (ssel_rise) begin
                  state_q <= IDLE;             // Short frame dropped
               end else if (sck_rise) begin
                  bit_cnt_q <= bit_cnt_q + 3'd1;
                  if (bit_cnt_q == 3'd7) begin
                     cmd_q     <= {shift_q[6:0], mosi_q[1]};
                     miso_sr_q <= '0;
                     state_q   <= shift_q[6] ? DATA : BUS_READ; // MSB set is a write
                  end
               end
            end
            BUS_READ: begin
               if (bus_ack_i) begin
                  stb_q     <= 1'b0;
                  miso_sr_q <= bus_dat_i;      // Valid in ack cycle
                  state_q   <= DATA;
               end else begin
                  stb_q <= 1'b1;
               end
            end
            DATA: begin
               if (ssel_rise) begin
                  state_q <= IDLE;
               end else begin
                  if (sck_fall) begin          // MISO moves on falling SCK
                     spi_miso_o <= miso_sr_q[7];
                     miso_sr_q  <= {miso_sr_q[6:0], 1'b0};
                  end
                  if (sck_rise) begin
                     bit_cnt_q <= bit_cnt_q + 3'd1;
                     if (bit_cnt_q == 3'd7)
                        state_q <= cmd_q[7] ? BUS_WRITE : IDLE;
                  end
               end
            end
            BUS_WRITE: begin
               if (bus_ack_i) begin
                  stb_q   <= 1'b0;
                  state_q <= IDLE;
               end else begin
                  stb_q <= 1'b1;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign bus_cyc_o = stb_q;        // Single-beat cycles only
   assign bus_stb_o = stb_q;
   assign bus_we_o  = cmd_q[7];
   assign bus_adr_o = cmd_q[6:0];
   assign bus_dat_o = shift_q;      // Stable once the data byte is in

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
   input  wire                 b_clk,
   input  wire                 arst_n_i,
   input  wire                 bus_stb_i,
   input  wire tart_pkg::bus_adr_t bus_adr_i,
   output logic                bus_ack_o,
   output tart_pkg::bus_data_t bus_dat_o,
   output logic                acq_stb_o,
   output logic                ctl_stb_o,
   input  wire                 acq_ack_i,
   input  wire                 ctl_ack_i,
   input  wire tart_pkg::bus_data_t acq_dat_i,
   input  wire tart_pkg::bus_data_t ctl_dat_i
);
   import tart_pkg::*;

   logic acq_hit;
   logic ctl_hit;
   logic nomap_ack_q;   // Ack for holes in the map

   // Region decode
   assign acq_hit = (bus_adr_i[6:4] == ACQ_REGION);
   assign ctl_hit = (bus_adr_i[6:3] == CTL_REGION);

   assign acq_stb_o = bus_stb_i & acq_hit;
   assign ctl_stb_o = bus_stb_i & ctl_hit;

   // Unmapped strobe still completes, one cycle later
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i)
         nomap_ack_q <= 1'b0;
      else
         nomap_ack_q <= bus_stb_i & ~acq_hit & ~ctl_hit & ~nomap_ack_q;
   end

   assign bus_ack_o = acq_ack_i | ctl_ack_i | nomap_ack_q;

   // Read mux, same decode as strobes
   always_comb begin
      if (acq_hit)
         bus_dat_o = acq_dat_i;
      else if (ctl_hit)
         bus_dat_o = ctl_dat_i;
      else
         bus_dat_o = '0;          // Unmapped reads as zero
   end

endmodule

`default_nettype wire

//--- hw/reset_control.sv
`timescale 1ns/1ps
`default_nettype none

module reset_control (
   input  wire                 b_clk,
   input  wire                 arst_n_i,
   input  wire                 stb_i,
   input  wire                 we_i,
   input  wire tart_pkg::bus_adr_t  adr_i,
   input  wire tart_pkg::bus_data_t dat_i,
   output logic                ack_o,
   output tart_pkg::bus_data_t dat_o,
   output logic                sys_rst_o
);
   import tart_pkg::*;

   logic                 access;
   logic                 ack_q;
   logic                 rst_req_q;   // Pulses with the ack of a reset write
   logic [RST_CNT_W-1:0] rst_cnt_q;   // Cycles of reset left
   bus_data_t            scratch_q;
   bus_data_t            rdat_q;

   assign access = stb_i & ~ack_q;    // First cycle of a strobe only

   // --------------------------------------------------
   // Ack, scratch and reset stretcher
   // --------------------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q     <= 1'b0;
         rst_req_q <= 1'b0;
         rst_cnt_q <= '0;
         scratch_q <= '0;
      end else begin
         ack_q     <= access;
         rst_req_q <= access & we_i & (adr_i == ADR_CTL_RESET) & dat_i[0];

         if (access && we_i && adr_i == ADR_CTL_SCRATCH)
            scratch_q <= dat_i;     // Untouched by sys_rst

         // Load in ack cycle, so reset starts the cycle after
         if (rst_req_q)
            rst_cnt_q <= RST_CNT_W'(RESET_CYCLES);
         else if (rst_cnt_q != '0)
            rst_cnt_q <= rst_cnt_q - 1'b1;
      end
   end

   assign sys_rst_o = (rst_cnt_q != '0);

   // Read data captured at strobe, shown in ack cycle
   always_ff @(posedge b_clk) begin
      if (access) begin
         case (adr_i)
            ADR_CTL_RESET:   rdat_q <= {7'd0, sys_rst_o};  // Reset still active
            ADR_CTL_SCRATCH: rdat_q <= scratch_q;
            default:         rdat_q <= '0;
         endcase
      end
   end

   assign ack_o = ack_q;
   assign dat_o = rdat_q;

endmodule

`default_nettype wire

//--- hw/acquire_regs.sv
`timescale 1ns/1ps
`default_nettype none

module acquire_regs (
   input  wire                 b_clk,
   input  wire                 arst_n_i,
   input  wire                 sys_rst_i,    // Synchronous, from reset_control
   input  wire                 stb_i,
   input  wire                 we_i,
   input  wire tart_pkg::bus_adr_t  adr_i,
   input  wire tart_pkg::bus_data_t dat_i,
   output logic                ack_o,
   output tart_pkg::bus_data_t dat_o,
   output logic                aq_enable_o,
   output tart_pkg::ax_delay_t aq_delay_o,
   input  wire tart_pkg::bus_data_t checksum_i,
   input  wire tart_pkg::bus_data_t sample_i
);
   import tart_pkg::*;

   logic      access;
   logic      ack_q;
   logic      enable_q;
   ax_delay_t delay_q;
   bus_data_t rdat_q;

   assign access = stb_i & ~ack_q;

   // --------------------------------------------------
   // Control register, bit 0 enable, bits 3:1 delay
   // --------------------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q    <= 1'b0;
         enable_q <= 1'b0;
         delay_q  <= '0;
      end else begin
         ack_q <= access;                // Bus keeps running through sys_rst
         if (sys_rst_i) begin
            enable_q <= 1'b0;
            delay_q  <= '0;
         end else if (access && we_i && adr_i == ADR_ACQ_CTRL) begin
            enable_q <= dat_i[0];
            delay_q  <= dat_i[3:1];
         end
      end
   end

   // Read-back mux
   always_ff @(posedge b_clk) begin
      if (access) begin
         case (adr_i)
            ADR_ACQ_CTRL:   rdat_q <= {4'd0, delay_q, enable_q};
            ADR_ACQ_CSUM:   rdat_q <= checksum_i;
            ADR_ACQ_SAMPLE: rdat_q <= sample_i;
            default:        rdat_q <= '0;     // Holes in region
         endcase
      end
   end

   assign ack_o       = ack_q;
   assign dat_o       = rdat_q;
   assign aq_enable_o = enable_q;
   assign aq_delay_o  = delay_q;

endmodule

`default_nettype wire

//--- hw/antenna_capture.sv
`timescale 1ns/1ps
`default_nettype none

module antenna_capture (
   input  wire                 b_clk,
   input  wire                 arst_n_i,
   input  wire                 sys_rst_i,
   input  wire tart_pkg::ax_data_t  antenna_i,
   input  wire                 aq_enable_i,
   input  wire tart_pkg::ax_delay_t aq_delay_i,
   output tart_pkg::bus_data_t checksum_o,
   output tart_pkg::bus_data_t sample_o
);
   import tart_pkg::*;

   ax_data_t  line_q [DELAY_TAPS-1];   // Older samples, line_q[0] newest
   ax_data_t  taps   [DELAY_TAPS];     // taps[d] feeds sample for delay d
   ax_data_t  sample_q;                // Last stage of the line
   bus_data_t csum_q;

   // --------------------------------------------------
   // Delay line and tap select
   // --------------------------------------------------
   always_comb begin
      taps[0] = antenna_i;             // Delay 0 is one cycle through sample_q
      for (int i = 1; i < DELAY_TAPS; i++)
         taps[i] = line_q[i-1];
   end

   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < DELAY_TAPS - 1; i++)
            line_q[i] <= '0;
         sample_q <= '0;
      end else if (sys_rst_i) begin
         for (int i = 0; i < DELAY_TAPS - 1; i++)
            line_q[i] <= '0;
         sample_q <= '0;
      end else begin
         line_q[0] <= antenna_i;
         for (int i = 1; i < DELAY_TAPS - 1; i++)
            line_q[i] <= line_q[i-1];
         sample_q <= taps[aq_delay_i];  // antenna_i from delay+1 cycles back
      end
   end

   // --------------------------------------------------
   // Checksum, wraps at 256
   // --------------------------------------------------
   always_ff @(posedge b_clk or negedge arst_n_i) begin
      if (!arst_n_i)
         csum_q <= '0;
      else if (sys_rst_i)
         csum_q <= '0;
      else if (aq_enable_i)
         csum_q <= csum_q + sample_q;  // Holds while disabled
   end

   assign checksum_o = csum_q;
   assign sample_o   = sample_q;

endmodule

`default_nettype wire

//--- hw/tart_lite_top.sv
`timescale 1ns/1ps
`default_nettype none

module tart_lite_top (
   input  wire                     b_clk,
   input  wire                     arst_n_i,
   input  wire                     spi_sck_i,
   input  wire                     spi_ssel_i,
   input  wire                     spi_mosi_i,
   output logic                    spi_miso_o,
   input  wire tart_pkg::ax_data_t antenna_i,
   output logic                    led_o
);
   import tart_pkg::*;

   // Bus master side
   bus_adr_t  bus_adr;
   bus_data_t bus_wdat;
   bus_data_t bus_rdat;
   logic      bus_stb;
   logic      bus_we;
   logic      bus_ack;

   // Per-slave strobes, acks, read data
   logic      acq_stb;
   logic      acq_ack;
   bus_data_t acq_rdat;
   logic      ctl_stb;
   logic      ctl_ack;
   bus_data_t ctl_rdat;

   // Acquisition control and status
   logic      sys_rst;
   logic      aq_enable;
   ax_delay_t aq_delay;
   bus_data_t checksum;
   bus_data_t sample;

   // --------------------------------------------------
   // SPI to bus, and decode
   // --------------------------------------------------
   spi_bus_bridge bridge_i (
      .b_clk(b_clk), .arst_n_i(arst_n_i),
      .spi_sck_i(spi_sck_i), .spi_ssel_i(spi_ssel_i), .spi_mosi_i(spi_mosi_i),
      .spi_miso_o(spi_miso_o),
      .bus_cyc_o(),                    // Mirrors strobe, no slave needs it
      .bus_stb_o(bus_stb), .bus_we_o(bus_we), .bus_adr_o(bus_adr),
      .bus_dat_o(bus_wdat), .bus_ack_i(bus_ack), .bus_dat_i(bus_rdat));

   bus_decoder decoder_i (
      .b_clk(b_clk), .arst_n_i(arst_n_i),
      .bus_stb_i(bus_stb), .bus_adr_i(bus_adr),
      .bus_ack_o(bus_ack), .bus_dat_o(bus_rdat),
      .acq_stb_o(acq_stb), .ctl_stb_o(ctl_stb),
      .acq_ack_i(acq_ack), .ctl_ack_i(ctl_ack),
      .acq_dat_i(acq_rdat), .ctl_dat_i(ctl_rdat));

   // --------------------------------------------------
   // Slaves and capture
   // --------------------------------------------------
   reset_control reset_ctl_i (
      .b_clk(b_clk), .arst_n_i(arst_n_i),
      .stb_i(ctl_stb), .we_i(bus_we), .adr_i(bus_adr), .dat_i(bus_wdat),
      .ack_o(ctl_ack), .dat_o(ctl_rdat), .sys_rst_o(sys_rst));

   acquire_regs acq_regs_i (
      .b_clk(b_clk), .arst_n_i(arst_n_i), .sys_rst_i(sys_rst),
      .stb_i(acq_stb), .we_i(bus_we), .adr_i(bus_adr), .dat_i(bus_wdat),
      .ack_o(acq_ack), .dat_o(acq_rdat),
      .aq_enable_o(aq_enable), .aq_delay_o(aq_delay),
      .checksum_i(checksum), .sample_i(sample));

   antenna_capture capture_i (
      .b_clk(b_clk), .arst_n_i(arst_n_i), .sys_rst_i(sys_rst),
      .antenna_i(antenna_i), .aq_enable_i(aq_enable), .aq_delay_i(aq_delay),
      .checksum_o(checksum), .sample_o(sample));

   assign led_o = aq_enable;           // Lit while capturing

endmodule

`default_nettype wire

//--- verif/tart_lite_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tart_lite_sva #(
   parameter bit CHECK_BUS = 1'b1    // Bus side or capture side
) (
   input wire                      b_clk,
   input wire                      arst_n_i,
   input wire                      stb_i,
   input wire                      ack_i,
   input wire tart_pkg::bus_adr_t  adr_i,
   input wire tart_pkg::ax_data_t  antenna_i,
   input wire tart_pkg::ax_delay_t delay_i,
   input wire tart_pkg::bus_data_t sample_i,
   input wire                      sys_rst_i
);
   import tart_pkg::*;

   int unsigned fail_cnt = 0;        // Failed assertions so far

   if (CHECK_BUS) begin : g_bus
      // Strobe held with a fixed address until ack
      stb_held: assert property (@(posedge b_clk) disable iff (!arst_n_i)
                                 stb_i && !ack_i |=> stb_i && $stable(adr_i))
         else begin
            $error("Strobe dropped or address moved before acknowledge");
            fail_cnt++;
         end

      ack_single: assert property (@(posedge b_clk) disable iff (!arst_n_i)
                                   ack_i |=> !ack_i)
         else begin
            $error("Acknowledge longer than one cycle");
            fail_cnt++;
         end

      ack_in_cycle: assert property (@(posedge b_clk) disable iff (!arst_n_i)
                                     ack_i |-> stb_i)   // No ack without a strobe
         else begin
            $error("Acknowledge outside a bus cycle");
            fail_cnt++;
         end
   end else begin : g_capture
      // Delay zero is a single register stage
      delay_zero: assert property (@(posedge b_clk) disable iff (!arst_n_i)
                                   !sys_rst_i && delay_i == '0 |=>
                                   sample_i == $past(antenna_i))
         else begin
            $error("Sample with delay zero is not last cycle's antenna word");
            fail_cnt++;
         end
   end

endmodule

// --------------------------------------------------
// Attach to the bridge and to the capture block
// --------------------------------------------------
bind spi_bus_bridge tart_lite_sva #(.CHECK_BUS(1'b1)) bus_sva_i (
   .b_clk(b_clk), .arst_n_i(arst_n_i),
   .stb_i(bus_stb_o), .ack_i(bus_ack_i), .adr_i(bus_adr_o),
   .antenna_i('0), .delay_i('0), .sample_i('0), .sys_rst_i(1'b0));

bind antenna_capture tart_lite_sva #(.CHECK_BUS(1'b0)) cap_sva_i (
   .b_clk(b_clk), .arst_n_i(arst_n_i),
   .stb_i(1'b0), .ack_i(1'b0), .adr_i('0),
   .antenna_i(antenna_i), .delay_i(aq_delay_i), .sample_i(sample_o),
   .sys_rst_i(sys_rst_i));

`default_nettype wire

//--- verif/tart_lite_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tart_lite_tb;
   import tart_pkg::*;

   localparam int HALF_SCK    = 8;    // b_clk cycles per SCK half period
   localparam int ACK_TIMEOUT = 200;
   localparam int RST_TIMEOUT = 50;
   localparam int BURST_LEN   = 24;

   logic      b_clk;
   logic      arst_n;
   logic      spi_sck;
   logic      spi_ssel;
   logic      spi_mosi;
   wire       spi_miso;
   ax_data_t  antenna;
   wire       led;

   integer    seed;
   logic      noise_on;               // Random antenna words in background
   ax_data_t  noise_word;             // Drawn at the edge, driven 1 ns later
   int        rst_high_cycles;        // Length of last sys_rst pulse
   bus_data_t model [128];            // Expected read value per address

   tart_lite_top dut_i (
      .b_clk(b_clk), .arst_n_i(arst_n),
      .spi_sck_i(spi_sck), .spi_ssel_i(spi_ssel), .spi_mosi_i(spi_mosi),
      .spi_miso_o(spi_miso), .antenna_i(antenna), .led_o(led));

   initial begin
      b_clk = 1'b0;
      forever #5 b_clk = ~b_clk;
   end

   always begin
      @(posedge b_clk);
      if (noise_on) begin
         noise_word = ax_data_t'($random(seed));
         #1;
         antenna = noise_word;
      end
   end

   always @(negedge b_clk)
      if (dut_i.sys_rst)
         rst_high_cycles = rst_high_cycles + 1;

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   task automatic step_cycles(input int n);
      repeat (n) begin
         @(posedge b_clk);
         #1;                          // Inputs move just after the edge
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s, at time %0t", why, $time);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_equal(input bus_data_t got, input bus_data_t exp, input string what);
      if (got !== exp) begin
         $display("Error at %0t: %s, got %02h, expected %02h", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   // Half an SCK period stretched until the bus ack if one is due
   task automatic sck_half(input bit want_ack);
      int n;
      bit seen;
      n    = 0;
      seen = 1'b0;
      while (n < HALF_SCK || (want_ack && !seen)) begin
         if (n >= ACK_TIMEOUT) begin
            abort_run("Timeout: the bus never acknowledged the transfer");
         end else begin
            step_cycles(1);
            n++;
            if (dut_i.bus_ack)
               seen = 1'b1;
         end
      end
   endtask

   // One mode-0 frame of command byte then data byte
   task automatic spi_transfer(input bit we, input bus_adr_t adr, input bus_data_t wdat,
                               output bus_data_t rdat);
      bus_data_t cmd;
      cmd      = {we, adr};
      rdat     = '0;
      spi_ssel = 1'b0;
      step_cycles(HALF_SCK);          // Let the bridge see the frame start
      for (int i = 7; i >= 0; i--) begin
         spi_mosi = cmd[i];
         step_cycles(HALF_SCK);
         spi_sck  = 1'b1;
         sck_half(i == 0 && !we);     // Read runs after the command
         spi_sck  = 1'b0;
      end
      for (int i = 7; i >= 0; i--) begin
         spi_mosi = wdat[i];
         step_cycles(HALF_SCK);
         rdat[i]  = spi_miso;         // Settled since the falling edge
         spi_sck  = 1'b1;
         sck_half(i == 0 && we);      // Write runs after the data byte
         spi_sck  = 1'b0;
      end
      step_cycles(HALF_SCK);
      spi_ssel = 1'b1;
      step_cycles(HALF_SCK);
   endtask

   // Register behaviour as the address map defines it
   task automatic model_write(input bus_adr_t adr, input bus_data_t dat);
      if (adr == ADR_ACQ_CTRL) begin
         model[adr] = dat & 8'h0F;    // Bits 7:4 read as zero
      end else if (adr == ADR_CTL_SCRATCH) begin
         model[adr] = dat;
      end else if (adr == ADR_CTL_RESET && dat[0]) begin
         model[ADR_ACQ_CTRL]   = '0;  // Scratch survives
         model[ADR_ACQ_CSUM]   = '0;
         model[ADR_ACQ_SAMPLE] = '0;
      end
   endtask

   task automatic write_reg(input bus_adr_t adr, input bus_data_t dat);
      bus_data_t miso_byte;
      spi_transfer(1'b1, adr, dat, miso_byte);
      model_write(adr, dat);
   endtask

   task automatic read_check(input bus_adr_t adr, input string what);
      bus_data_t got;
      spi_transfer(1'b0, adr, 8'h00, got);
      check_equal(got, model[adr], what);
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (dut_i.sys_rst) begin
         if (n >= RST_TIMEOUT) begin
            abort_run("Timeout: software reset never released");
         end else begin
            step_cycles(1);
            n++;
         end
      end
   endtask

   function automatic bus_adr_t random_unmapped();
      int unsigned r;
      r = $unsigned($random(seed));
      return bus_adr_t'(7'h10 + r % 104);  // 0x10 to 0x77 between the two regions
   endfunction

   // --------------------------------------------------
   // Scenarios
   // --------------------------------------------------
   initial begin
      bus_data_t value;
      ax_delay_t delay;
      bus_data_t sum;
      bus_adr_t  adr;
      seed            = 77;
      arst_n          = 1'b0;
      spi_sck         = 1'b0;
      spi_ssel        = 1'b1;
      spi_mosi        = 1'b0;
      antenna         = '0;
      noise_on        = 1'b0;
      rst_high_cycles = 0;
      for (int a = 0; a < 128; a++)
         model[a] = '0;
      repeat (5) @(posedge b_clk);
      #1;
      arst_n = 1'b1;
      step_cycles(2);

      for (int k = 0; k < 20; k++) begin    // Scratch
         write_reg(ADR_CTL_SCRATCH, bus_data_t'($random(seed)));
         read_check(ADR_CTL_SCRATCH, "scratch read-back");
      end

      for (int k = 0; k < 10; k++) begin    // Control register and LED
         value = bus_data_t'($random(seed));
         write_reg(ADR_ACQ_CTRL, value);
         read_check(ADR_ACQ_CTRL, "control read-back");
         check_equal({7'd0, led}, {7'd0, value[0]}, "led follows enable");
      end

      // Checksum over a burst is independent of delay
      delay = ax_delay_t'($random(seed));
      sum   = '0;
      read_check(ADR_ACQ_CSUM, "checksum before burst");
      write_reg(ADR_ACQ_CTRL, {4'd0, delay, 1'b1});
      for (int k = 0; k < BURST_LEN; k++) begin
         antenna = ax_data_t'($random(seed));
         sum     = sum + antenna;
         step_cycles(1);
      end
      antenna = '0;
      step_cycles(12);                      // Flush the longest delay
      write_reg(ADR_ACQ_CTRL, {4'd0, delay, 1'b0});
      model[ADR_ACQ_CSUM] = model[ADR_ACQ_CSUM] + sum;
      read_check(ADR_ACQ_CSUM, "checksum after burst");
      read_check(ADR_ACQ_SAMPLE, "sample after burst");

      noise_on = 1'b1;                      // Hold while disabled
      read_check(ADR_ACQ_CSUM, "checksum hold, first read");
      read_check(ADR_ACQ_CSUM, "checksum hold, second read");
      noise_on = 1'b0;
      step_cycles(1);                       // Last noise word lands first
      antenna  = '0;

      // Software reset
      write_reg(ADR_CTL_SCRATCH, bus_data_t'($random(seed)));
      write_reg(ADR_ACQ_CTRL, bus_data_t'($random(seed)) | 8'h01);
      rst_high_cycles = 0;
      write_reg(ADR_CTL_RESET, 8'h01);
      wait_reset_release();
      check_equal(8'(rst_high_cycles), 8'(RESET_CYCLES), "software reset length");
      read_check(ADR_ACQ_CTRL, "control after reset");
      read_check(ADR_ACQ_CSUM, "checksum after reset");
      read_check(ADR_CTL_SCRATCH, "scratch after reset");
      read_check(ADR_CTL_RESET, "reset status after pulse");

      noise_on = 1'b1;                      // Delay is zero again after reset
      for (int k = 0; k < 10; k++) begin    // Holes in the map
         adr = random_unmapped();
         read_check(adr, $sformatf("unmapped read of %02h", adr));
         write_reg(adr, bus_data_t'($random(seed)));
      end
      read_check(ADR_ACQ_CTRL, "control after unmapped writes");
      read_check(ADR_ACQ_CSUM, "checksum after unmapped writes");
      read_check(ADR_CTL_SCRATCH, "scratch after unmapped writes");

      if (dut_i.bridge_i.bus_sva_i.fail_cnt + dut_i.capture_i.cap_sva_i.fail_cnt == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("Assertion failures were reported during the run");
         $display("RESULT: FAIL");
         $fatal(1, "assertion failures");
      end
   end

endmodule

`default_nettype wire

//--- tart_lite.f
hw/tart_pkg.sv
hw/spi_bus_bridge.sv
hw/bus_decoder.sv
hw/reset_control.sv
hw/acquire_regs.sv
hw/antenna_capture.sv
hw/tart_lite_top.sv
verif/tart_lite_sva.sv
verif/tart_lite_tb.sv

//--- Makefile
TOP  := tart_lite_tb
SRCS := $(shell cat tart_lite.f)

.PHONY: all run check clean

all: check

obj_dir/V%: tart_lite.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tart_lite.f --top-module $* -o V$*

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log

check: run
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
